// File: hw/dp_core_pkg.sv
// Execution core shared definitions
`default_nettype none

package dp_core_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 4;
  localparam int NUM_REGS   = 16;

  // Instruction class field, bits 27:25
  localparam logic [2:0] CLASS_DP_REG = 3'b000;  // Register with immediate shift
  localparam logic [2:0] CLASS_DP_IMM = 3'b001;  // Rotated 8-bit immediate

  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_ADC    = 4'b0001,
    ALU_SUB    = 4'b0010,
    ALU_SBC    = 4'b0011,
    ALU_RSB    = 4'b0100,
    ALU_RSC    = 4'b0101,
    ALU_AND    = 4'b0110,
    ALU_ORR    = 4'b0111,
    ALU_EOR    = 4'b1000,
    ALU_PASS_A = 4'b1001,
    ALU_PASS_B = 4'b1010,
    ALU_NOT_B  = 4'b1011,
    ALU_BIC    = 4'b1100
  } alu_op_e;

  // Data-processing opcode field, bits 24:21
  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN, OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } dp_opcode_e;

  typedef enum logic {SHIFT_IMM_ROT, SHIFT_REG_IMM} shift_mode_e;

  typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shift_type_e;

  typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_WB} fwd_sel_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;  // Borrow after a subtraction
    logic v;
  } flags_t;

endpackage

`default_nettype wire

// File: hw/dp_decoder.sv
// Data-processing instruction decoder
`default_nettype none
`timescale 1ns/10ps

module dp_decoder (
  input  wire [dp_core_pkg::DATA_W-1:0]       instr,
  input  wire                                 instr_valid,
  output logic                                dec_valid,
  output dp_core_pkg::alu_op_e                alu_op,
  output dp_core_pkg::shift_mode_e            shift_mode,
  output logic                                set_flags,
  output logic                                reg_write,
  output logic [dp_core_pkg::REG_ADDR_W-1:0]  rn,
  output logic [dp_core_pkg::REG_ADDR_W-1:0]  rm,
  output logic [dp_core_pkg::REG_ADDR_W-1:0]  rd,
  output logic                                uses_rm
);
  import dp_core_pkg::*;

  logic [2:0] instr_class;
  dp_opcode_e opcode;
  logic       is_imm_form;
  logic       is_reg_form;

  assign instr_class = instr[27:25];
  assign opcode      = dp_opcode_e'(instr[24:21]);

  assign is_imm_form = (instr_class == CLASS_DP_IMM);
  assign is_reg_form = (instr_class == CLASS_DP_REG) && !instr[4];  // Bit 4 high is shift by register

  // Anything else travels down the pipe as a bubble
  assign dec_valid = instr_valid && (is_imm_form || is_reg_form);

  assign set_flags  = instr[20];
  assign shift_mode = is_imm_form ? SHIFT_IMM_ROT : SHIFT_REG_IMM;
  assign uses_rm    = is_reg_form;

  assign rn = instr[19:16];
  assign rd = instr[15:12];
  assign rm = instr[3:0];

  // Compare and test opcodes only update the status register
  assign reg_write = !(opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});

  always_comb begin
    case (opcode)
      OP_AND, OP_TST: alu_op = ALU_AND;
      OP_EOR, OP_TEQ: alu_op = ALU_EOR;
      OP_SUB, OP_CMP: alu_op = ALU_SUB;
      OP_ADD, OP_CMN: alu_op = ALU_ADD;
      OP_RSB:         alu_op = ALU_RSB;
      OP_ADC:         alu_op = ALU_ADC;
      OP_SBC:         alu_op = ALU_SBC;
      OP_RSC:         alu_op = ALU_RSC;
      OP_ORR:         alu_op = ALU_ORR;
      OP_MOV:         alu_op = ALU_PASS_B;
      OP_BIC:         alu_op = ALU_BIC;
      default:        alu_op = ALU_NOT_B;  // MVN
    endcase
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// General purpose register file
`default_nettype none
`timescale 1ns/10ps

module reg_file (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 we,
  input  wire [dp_core_pkg::REG_ADDR_W-1:0]   waddr,
  input  wire [dp_core_pkg::DATA_W-1:0]       wdata,
  input  wire [dp_core_pkg::REG_ADDR_W-1:0]   raddr_a,
  input  wire [dp_core_pkg::REG_ADDR_W-1:0]   raddr_b,
  output logic [dp_core_pkg::DATA_W-1:0]      rdata_a,
  output logic [dp_core_pkg::DATA_W-1:0]      rdata_b
);
  import dp_core_pkg::*;

  logic [DATA_W-1:0] regs [NUM_REGS];

  // R15 is an ordinary register here
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Reads see a write as soon as the edge has passed
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// File: hw/forward_unit.sv
// Operand forwarding select logic
`default_nettype none
`timescale 1ns/10ps

module forward_unit (
  input  wire [dp_core_pkg::REG_ADDR_W-1:0]   rn,
  input  wire [dp_core_pkg::REG_ADDR_W-1:0]   rm,
  input  wire                                 uses_rm,
  input  wire [dp_core_pkg::REG_ADDR_W-1:0]   ex_rd,
  input  wire                                 ex_write,
  input  wire [dp_core_pkg::REG_ADDR_W-1:0]   wb_rd,
  input  wire                                 wb_write,
  output dp_core_pkg::fwd_sel_e               fwd_a,
  output dp_core_pkg::fwd_sel_e               fwd_b
);
  import dp_core_pkg::*;

  // Youngest producer wins
  function automatic fwd_sel_e source_of(input logic [REG_ADDR_W-1:0] src);
    if (ex_write && (src == ex_rd)) begin
      return FWD_EX;
    end else if (wb_write && (src == wb_rd)) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  always_comb begin
    fwd_a = source_of(rn);
    fwd_b = uses_rm ? source_of(rm) : FWD_RF;  // Immediate form has no Rm
  end

endmodule

`default_nettype wire

// File: hw/operand_shifter.sv
// Second operand shifter
`default_nettype none
`timescale 1ns/10ps

module operand_shifter (
  input  wire [dp_core_pkg::DATA_W-1:0]       rm_value,
  input  wire [11:0]                          imm_field,
  input  wire dp_core_pkg::shift_mode_e       shift_mode,
  output logic [dp_core_pkg::DATA_W-1:0]      operand_b
);
  import dp_core_pkg::*;

  logic [DATA_W-1:0] imm_value;
  logic [4:0]        rot_amt;
  logic [4:0]        shift_amt;
  shift_type_e       shift_type;

  function automatic logic [DATA_W-1:0] rotate_right(
    input logic [DATA_W-1:0] value,
    input logic [4:0]        amount
  );
    logic [2*DATA_W-1:0] doubled;
    doubled = {value, value} >> amount;
    return doubled[DATA_W-1:0];
  endfunction

  assign imm_value  = {{(DATA_W-8){1'b0}}, imm_field[7:0]};
  assign rot_amt    = {imm_field[11:8], 1'b0};  // Twice the rotate field
  assign shift_amt  = imm_field[11:7];
  assign shift_type = shift_type_e'(imm_field[6:5]);

  always_comb begin
    if (shift_mode == SHIFT_IMM_ROT) begin
      operand_b = rotate_right(imm_value, rot_amt);
    end else begin
      case (shift_type)
        SH_LSL:  operand_b = rm_value << shift_amt;
        SH_LSR:  operand_b = rm_value >> shift_amt;  // Amount 0 passes Rm
        SH_ASR:  operand_b = $signed(rm_value) >>> shift_amt;
        default: operand_b = rotate_right(rm_value, shift_amt);
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/alu.sv
// Arithmetic and logic unit
`default_nettype none
`timescale 1ns/10ps

module alu (
  input  wire [dp_core_pkg::DATA_W-1:0]       a,
  input  wire [dp_core_pkg::DATA_W-1:0]       b,
  input  wire dp_core_pkg::alu_op_e           alu_op,
  input  wire dp_core_pkg::flags_t            flags_in,
  output logic [dp_core_pkg::DATA_W-1:0]      result,
  output dp_core_pkg::flags_t                 flags_out
);
  import dp_core_pkg::*;

  logic [DATA_W:0]   wide;      // Extra bit is carry, or borrow on subtraction
  logic [DATA_W:0]   cin_ext;
  logic [DATA_W-1:0] logic_res;
  logic              arith;
  logic              v_new;
  logic              a_msb;
  logic              b_msb;

  assign cin_ext = {{DATA_W{1'b0}}, flags_in.c};
  assign a_msb   = a[DATA_W-1];
  assign b_msb   = b[DATA_W-1];

  always_comb begin
    wide      = '0;
    logic_res = '0;
    arith     = 1'b1;
    v_new     = flags_in.v;
    case (alu_op)
      ALU_ADD: begin
        wide  = {1'b0, a} + {1'b0, b};
        v_new = ~(a_msb ^ b_msb) & (a_msb ^ wide[DATA_W-1]);
      end
      ALU_ADC: begin
        wide  = {1'b0, a} + {1'b0, b} + cin_ext;
        v_new = ~(a_msb ^ b_msb) & (a_msb ^ wide[DATA_W-1]);
      end
      ALU_SUB: begin
        wide  = {1'b0, a} - {1'b0, b};  // Top bit set when a < b
        v_new = (a_msb ^ b_msb) & (a_msb ^ wide[DATA_W-1]);
      end
      ALU_SBC: begin
        wide  = {1'b0, a} - {1'b0, b} - cin_ext;
        v_new = (a_msb ^ b_msb) & (a_msb ^ wide[DATA_W-1]);
      end
      ALU_RSB: begin
        wide  = {1'b0, b} - {1'b0, a};
        v_new = (b_msb ^ a_msb) & (b_msb ^ wide[DATA_W-1]);
      end
      ALU_RSC: begin
        wide  = {1'b0, b} - {1'b0, a} - cin_ext;
        v_new = (b_msb ^ a_msb) & (b_msb ^ wide[DATA_W-1]);
      end
      default: begin
        arith = 1'b0;
        case (alu_op)
          ALU_AND:    logic_res = a & b;
          ALU_ORR:    logic_res = a | b;
          ALU_EOR:    logic_res = a ^ b;
          ALU_PASS_A: logic_res = a;
          ALU_PASS_B: logic_res = b;
          ALU_NOT_B:  logic_res = ~b;
          default:    logic_res = a & ~b;  // BIC
        endcase
      end
    endcase

    result      = arith ? wide[DATA_W-1:0] : logic_res;
    flags_out.n = result[DATA_W-1];
    flags_out.z = (result == '0);
    flags_out.c = arith ? wide[DATA_W] : flags_in.c;  // Logical ops keep C and V
    flags_out.v = v_new;
  end

endmodule

`default_nettype wire

// File: hw/dp_core_top.sv
// Three-stage data-processing core
`default_nettype none
`timescale 1ns/10ps

module dp_core_top (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 instr_valid,
  input  wire [dp_core_pkg::DATA_W-1:0]       instr,
  output logic                                wb_valid,
  output logic [dp_core_pkg::REG_ADDR_W-1:0]  wb_rd,
  output logic [dp_core_pkg::DATA_W-1:0]      wb_data,
  output dp_core_pkg::flags_t                 flags
);
  import dp_core_pkg::*;

  // Decode stage
  logic [DATA_W-1:0]     dec_instr;
  logic                  dec_instr_valid;
  logic                  dec_valid;
  alu_op_e               dec_alu_op;
  shift_mode_e           dec_shift_mode;
  logic                  dec_set_flags;
  logic                  dec_reg_write;
  logic [REG_ADDR_W-1:0] dec_rn;
  logic [REG_ADDR_W-1:0] dec_rm;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic                  dec_uses_rm;
  logic [DATA_W-1:0]     rdata_a;
  logic [DATA_W-1:0]     rdata_b;
  fwd_sel_e              fwd_a;
  fwd_sel_e              fwd_b;
  logic [DATA_W-1:0]     op_a;
  logic [DATA_W-1:0]     rm_value;

  // Execute stage
  logic                  ex_valid;
  logic                  ex_write;
  logic                  ex_set_flags;
  alu_op_e               ex_alu_op;
  shift_mode_e           ex_shift_mode;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [DATA_W-1:0]     ex_a;
  logic [DATA_W-1:0]     ex_rm_value;
  logic [11:0]           ex_imm;
  logic [DATA_W-1:0]     operand_b;
  logic [DATA_W-1:0]     alu_result;
  flags_t                alu_flags;

  function automatic logic [DATA_W-1:0] pick_operand(
    input fwd_sel_e          sel,
    input logic [DATA_W-1:0] rf_value,
    input logic [DATA_W-1:0] ex_value,
    input logic [DATA_W-1:0] wb_value
  );
    case (sel)
      FWD_EX:  return ex_value;
      FWD_WB:  return wb_value;
      default: return rf_value;
    endcase
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_instr_valid <= 1'b0;
    end else begin
      dec_instr_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      dec_instr <= instr;
    end
  end

  dp_decoder u_decoder (
    .instr       (dec_instr),
    .instr_valid (dec_instr_valid),
    .dec_valid   (dec_valid),
    .alu_op      (dec_alu_op),
    .shift_mode  (dec_shift_mode),
    .set_flags   (dec_set_flags),
    .reg_write   (dec_reg_write),
    .rn          (dec_rn),
    .rm          (dec_rm),
    .rd          (dec_rd),
    .uses_rm     (dec_uses_rm)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .we      (wb_valid),  // Retires one edge after writeback loads
    .waddr   (wb_rd),
    .wdata   (wb_data),
    .raddr_a (dec_rn),
    .raddr_b (dec_rm),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b)
  );

  forward_unit u_forward_unit (
    .rn       (dec_rn),
    .rm       (dec_rm),
    .uses_rm  (dec_uses_rm),
    .ex_rd    (ex_rd),
    .ex_write (ex_write),
    .wb_rd    (wb_rd),
    .wb_write (wb_valid),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b)
  );

  always_comb begin
    op_a     = pick_operand(fwd_a, rdata_a, alu_result, wb_data);
    rm_value = pick_operand(fwd_b, rdata_b, alu_result, wb_data);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_valid     <= 1'b0;
      ex_write     <= 1'b0;
      ex_set_flags <= 1'b0;
    end else begin
      ex_valid     <= dec_valid;
      ex_write     <= dec_valid && dec_reg_write;
      ex_set_flags <= dec_set_flags;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_op     <= dec_alu_op;
    ex_shift_mode <= dec_shift_mode;
    ex_rd         <= dec_rd;
    ex_a          <= op_a;
    ex_rm_value   <= rm_value;
    ex_imm        <= dec_instr[11:0];  // Rotate and imm8, or shift amount and type
  end

  operand_shifter u_operand_shifter (
    .rm_value   (ex_rm_value),
    .imm_field  (ex_imm),
    .shift_mode (ex_shift_mode),
    .operand_b  (operand_b)
  );

  alu u_alu (
    .a         (ex_a),
    .b         (operand_b),
    .alu_op    (ex_alu_op),
    .flags_in  (flags),  // Carry-in straight from the status register
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_valid <= 1'b0;
      flags    <= '0;
    end else begin
      wb_valid <= ex_write;
      if (ex_valid && ex_set_flags) begin
        flags <= alu_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ex_write) begin
      wb_rd   <= ex_rd;
      wb_data <= alu_result;
    end
  end

endmodule

`default_nettype wire

// File: verif/dp_core_tb.sv
// Execution core testbench
`default_nettype none
`timescale 1ns/10ps

module dp_core_tb;
  import dp_core_pkg::*;

  typedef struct {
    int                    idx;    // 0 for a bubble
    logic                  valid;
    logic [DATA_W-1:0]     instr;
    logic                  write;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     data;
    flags_t                flags;  // Status once this row has retired
  } row_t;

  logic                  clk;
  logic                  reset;
  logic                  instr_valid;
  logic [DATA_W-1:0]     instr;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [DATA_W-1:0]     wb_data;
  flags_t                flags;

  row_t   table_q[$];
  row_t   pending_q[$];  // Rows in flight, oldest first
  flags_t last_flags;

  dp_core_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .flags       (flags)
  );

  always #10 clk = ~clk;

  function automatic logic [DATA_W-1:0] enc_imm(input dp_opcode_e op, input logic s,
      input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rot,
      input logic [7:0] imm8);
    return {4'hE, 3'b001, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic logic [DATA_W-1:0] enc_reg(input dp_opcode_e op, input logic s,
      input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm,
      input logic [4:0] amt, input shift_type_e sh);
    return {4'hE, 3'b000, op, s, rn, rd, amt, sh, 1'b0, rm};
  endfunction

  task automatic stop_on_error;
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_data(input string what, input logic [DATA_W-1:0] got,
      input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, what, exp, got);
      stop_on_error();
    end
  endtask

  task automatic check_rd(input string what, input logic [REG_ADDR_W-1:0] got,
      input logic [REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s expected r%0d, got r%0d", $time, what, exp, got);
      stop_on_error();
    end
  endtask

  task automatic check_flags(input string what, input flags_t got, input flags_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s expected NZCV %b, got %b", $time, what, exp, got);
      stop_on_error();
    end
  endtask

  task automatic check_valid(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s expected %b, got %b", $time, what, exp, got);
      stop_on_error();
    end
  endtask

  task automatic check_row(input row_t e);
    string tag;
    tag = (e.idx > 0) ? $sformatf("row %0d", e.idx) : "bubble";
    check_valid({tag, " wb_valid"}, wb_valid, e.write);
    if (e.write) begin
      check_rd({tag, " wb_rd"}, wb_rd, e.rd);
      check_data({tag, " wb_data"}, wb_data, e.data);
    end
    check_flags({tag, " flags"}, flags, e.flags);
  endtask

  task automatic add_row(input logic [DATA_W-1:0] word, input logic write,
      input logic [REG_ADDR_W-1:0] rd, input logic [DATA_W-1:0] data,
      input logic [3:0] nzcv);
    row_t r;
    r.idx   = table_q.size() + 1;
    r.valid = 1'b1;
    r.instr = word;
    r.write = write;
    r.rd    = rd;
    r.data  = data;
    r.flags = flags_t'(nzcv);
    table_q.push_back(r);
  endtask

  function automatic row_t bubble_row();
    row_t r;
    r.idx   = 0;
    r.valid = 1'b0;
    r.instr = $urandom;  // Must be ignored while instr_valid is low
    r.write = 1'b0;
    r.rd    = '0;
    r.data  = '0;
    r.flags = last_flags;
    return r;
  endfunction

  // Outputs of a row are stable at the third falling edge after it is driven
  task automatic apply_row(input row_t r);
    row_t done;
    @(negedge clk);
    if (pending_q.size() == 3) begin
      done = pending_q.pop_front();
      check_row(done);
    end
    instr_valid = r.valid;
    instr       = r.instr;
    if (r.valid) begin
      last_flags = r.flags;
    end
    pending_q.push_back(r);
  endtask

  task automatic drain_pipeline;
    row_t done;
    int   cycles;
    cycles = 0;
    while (pending_q.size() > 0) begin
      if (cycles == 10) begin
        $display("Timeout: pipeline still holds rows after 10 drain cycles");
        stop_on_error();
      end
      @(negedge clk);
      done = pending_q.pop_front();
      check_row(done);
      instr_valid = 1'b0;
      cycles++;
    end
  endtask

  task automatic reset_dut;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    last_flags  = '0;
    pending_q.delete();
    repeat (8) @(negedge clk);
    reset = 1'b0;
    check_valid("wb_valid after reset", wb_valid, 1'b0);
    check_flags("flags after reset", flags, flags_t'(4'b0000));
  endtask

  task automatic build_table;
    // Rotated immediates, then EX, WB and register file sources
    add_row(enc_imm(OP_MOV, 1'b0, 4'd0, 4'd1, 4'd0, 8'hFF), 1'b1, 4'd1, 32'h0000_00FF, 4'b0000);
    add_row(enc_imm(OP_MOV, 1'b0, 4'd0, 4'd2, 4'd2, 8'h3F), 1'b1, 4'd2, 32'hF000_0003, 4'b0000);
    add_row(enc_imm(OP_ORR, 1'b0, 4'd1, 4'd3, 4'd12, 8'h0F), 1'b1, 4'd3, 32'h0000_0FFF, 4'b0000);
    add_row(enc_imm(OP_ADD, 1'b0, 4'd3, 4'd4, 4'd15, 8'h01), 1'b1, 4'd4, 32'h0000_1003, 4'b0000);
    add_row(enc_reg(OP_ADD, 1'b0, 4'd4, 4'd5, 4'd3, 5'd0, SH_LSL), 1'b1, 4'd5, 32'h0000_2002,
            4'b0000);
    add_row(enc_reg(OP_ADD, 1'b0, 4'd1, 4'd6, 4'd2, 5'd0, SH_LSL), 1'b1, 4'd6, 32'hF000_0102,
            4'b0000);
    add_row(enc_reg(OP_EOR, 1'b0, 4'd0, 4'd7, 4'd6, 5'd0, SH_LSL), 1'b1, 4'd7, 32'hF000_0102,
            4'b0000);
    // Immediate shifts of r2
    add_row(enc_reg(OP_MOV, 1'b0, 4'd0, 4'd8, 4'd2, 5'd4, SH_LSL), 1'b1, 4'd8, 32'h0000_0030,
            4'b0000);
    add_row(enc_reg(OP_MOV, 1'b0, 4'd0, 4'd9, 4'd2, 5'd8, SH_LSR), 1'b1, 4'd9, 32'h00F0_0000,
            4'b0000);
    add_row(enc_reg(OP_MOV, 1'b0, 4'd0, 4'd10, 4'd2, 5'd8, SH_ASR), 1'b1, 4'd10, 32'hFFF0_0000,
            4'b0000);
    add_row(enc_reg(OP_MOV, 1'b0, 4'd0, 4'd11, 4'd2, 5'd4, SH_ROR), 1'b1, 4'd11, 32'h3F00_0000,
            4'b0000);
    add_row(enc_reg(OP_MOV, 1'b0, 4'd0, 4'd12, 4'd11, 5'd24, SH_LSR), 1'b1, 4'd12,
            32'h0000_003F, 4'b0000);
    // Flags, carry chains and compares
    add_row(enc_reg(OP_ADD, 1'b1, 4'd2, 4'd13, 4'd2, 5'd0, SH_LSL), 1'b1, 4'd13, 32'hE000_0006,
            4'b1010);
    add_row(enc_imm(OP_ADC, 1'b0, 4'd0, 4'd14, 4'd0, 8'h00), 1'b1, 4'd14, 32'h0000_0001, 4'b1010);
    add_row(enc_reg(OP_SUB, 1'b1, 4'd3, 4'd15, 4'd1, 5'd0, SH_LSL), 1'b1, 4'd15, 32'h0000_0F00,
            4'b0000);
    add_row(enc_imm(OP_CMP, 1'b1, 4'd1, 4'd0, 4'd0, 8'hFF), 1'b0, 4'd0, 32'h0, 4'b0100);
    add_row(enc_imm(OP_TST, 1'b1, 4'd2, 4'd0, 4'd1, 8'h02), 1'b0, 4'd0, 32'h0, 4'b1000);
    add_row(enc_reg(OP_SUB, 1'b1, 4'd1, 4'd14, 4'd3, 5'd0, SH_LSL), 1'b1, 4'd14, 32'hFFFF_F100,
            4'b1010);  // Borrow sets C
    add_row(enc_imm(OP_SBC, 1'b0, 4'd1, 4'd14, 4'd0, 8'h00), 1'b1, 4'd14, 32'h0000_00FE, 4'b1010);
    add_row(enc_reg(OP_MOV, 1'b0, 4'd0, 4'd13, 4'd14, 5'd0, SH_LSL), 1'b1, 4'd13,
            32'h0000_00FE, 4'b1010);  // Newer of two r14 writers wins
    add_row(enc_reg(OP_ADD, 1'b1, 4'd11, 4'd12, 4'd11, 5'd1, SH_LSL), 1'b1, 4'd12,
            32'hBD00_0000, 4'b1001);  // Signed overflow
    // Shift by register and a load are not supported
    add_row(enc_reg(OP_ADD, 1'b1, 4'd1, 4'd2, 4'd1, 5'd6, SH_LSL) | 32'h0000_0010, 1'b0, 4'd0,
            32'h0, 4'b1001);
    add_row(32'hE591_2000, 1'b0, 4'd0, 32'h0, 4'b1001);
    add_row(enc_reg(OP_MOV, 1'b0, 4'd0, 4'd3, 4'd2, 5'd0, SH_LSL), 1'b1, 4'd3, 32'hF000_0003,
            4'b1001);
  endtask

  task automatic run_table(input int unsigned max_gap);
    int unsigned gap;
    foreach (table_q[i]) begin
      apply_row(table_q[i]);
      gap = (max_gap > 0) ? ($urandom % (max_gap + 1)) : 0;
      repeat (gap) apply_row(bubble_row());
    end
    drain_pipeline();
  endtask

  initial begin
    clk = 1'b0;
    void'($urandom(11));
    reset_dut();
    build_table();
    run_table(0);  // Back to back
    reset_dut();
    run_table(3);  // Same rows with random gaps
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/dp_core_pkg.sv
hw/dp_decoder.sv
hw/reg_file.sv
hw/forward_unit.sv
hw/operand_shifter.sv
hw/alu.sv
hw/dp_core_top.sv
verif/dp_core_tb.sv

// File: Makefile
TOP := dp_core_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
